// File: noc_link_pkg.sv
package noc_link_pkg;

  // Link and routing field widths
  localparam int flit_width_lp = 32;
  localparam int cord_width_lp = 4;
  localparam int cid_width_lp  = 2;
  localparam int did_width_lp  = 2;
  localparam int len_width_lp  = 2;

  // Every packet is one header flit followed by two payload flits
  localparam logic [len_width_lp-1:0] pkt_len_lp = 2'd2;

  // The I/O side of the chip sits at coordinate zero
  localparam logic [cord_width_lp-1:0] io_cord_lp = '0;

  // Outstanding commands whose return route is still held
  localparam int route_fifo_depth_lp = 16;
  localparam int route_ptr_width_lp  = $clog2(route_fifo_depth_lp);

  localparam int hdr_used_width_lp = 2 * cord_width_lp + len_width_lp
                                   + 2 * cid_width_lp + 2 * did_width_lp;
  localparam int hdr_pad_width_lp  = flit_width_lp - hdr_used_width_lp;

  // Header flit, most significant field first
  typedef struct packed {
    logic [cord_width_lp-1:0]    dst_cord;
    logic [len_width_lp-1:0]     len;
    logic [cord_width_lp-1:0]    src_cord;
    logic [cid_width_lp-1:0]     src_cid;
    logic [did_width_lp-1:0]     src_did;
    logic [cid_width_lp-1:0]     dst_cid;
    logic [did_width_lp-1:0]     dst_did;
    logic [hdr_pad_width_lp-1:0] pad;
  } wh_header_s;

  // Where the answer to a command has to go
  typedef struct packed {
    logic [cord_width_lp-1:0] cord;
    logic [cid_width_lp-1:0]  cid;
    logic [did_width_lp-1:0]  did;
  } return_route_s;

endpackage

// File: mem_msg_pkg.sv
package mem_msg_pkg;

  localparam int mem_opcode_width_lp = 4;
  localparam int mem_addr_width_lp   = 28;
  localparam int mem_data_width_lp   = 32;
  localparam int mem_msg_width_lp    = 64;

  typedef enum logic [mem_opcode_width_lp-1:0] {
    e_mem_rd    = 4'h0,
    e_mem_wr    = 4'h1,
    e_mem_uc_rd = 4'h2
  } mem_opcode_e;

  // Opcode and address form the upper flit, data the lower one
  typedef struct packed {
    mem_opcode_e                  opcode;
    logic [mem_addr_width_lp-1:0] addr;
    logic [mem_data_width_lp-1:0] data;
  } mem_msg_s;

endpackage

// File: return_route_if.sv
interface return_route_if;
  import noc_link_pkg::*;

  logic          push_v;
  logic          push_ready;
  return_route_s push_route;

  logic          pop_v;
  logic          pop_yumi;
  return_route_s pop_route;

  modport writer (
    output push_v, push_route,
    input  push_ready
  );

  modport fifo (
    input  push_v, push_route, pop_yumi,
    output push_ready, pop_v, pop_route
  );

  modport reader (
    input  pop_v, pop_route,
    output pop_yumi
  );

endinterface

// File: wh_cmd_link_adapter.sv
module wh_cmd_link_adapter (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 cmd_link_v_i,
  input  logic [noc_link_pkg::flit_width_lp-1:0] cmd_link_data_i,
  output logic                                 cmd_link_ready_o,
  output mem_msg_pkg::mem_msg_s                mem_cmd_o,
  output logic                                 mem_cmd_v_o,
  input  logic                                 mem_cmd_yumi_i,
  return_route_if.writer                       route
);
  import noc_link_pkg::*;
  import mem_msg_pkg::*;

  typedef enum logic [1:0] {
    e_cmd_header,
    e_cmd_payload_hi,
    e_cmd_payload_lo,
    e_cmd_wait_mem
  } cmd_state_e;

  cmd_state_e                 state_r;
  cmd_state_e                 state_n;
  logic                       ready_r;
  logic                       flit_fire;
  wh_header_s                 hdr_in;
  return_route_s              src_route_r;
  logic [flit_width_lp-1:0]   payload_hi_r;
  logic [flit_width_lp-1:0]   payload_lo_r;

  assign hdr_in    = wh_header_s'(cmd_link_data_i);
  assign flit_fire = cmd_link_v_i & ready_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_cmd_header:     if (flit_fire) state_n = e_cmd_payload_hi;
      e_cmd_payload_hi: if (flit_fire) state_n = e_cmd_payload_lo;
      e_cmd_payload_lo: if (flit_fire) state_n = e_cmd_wait_mem;
      e_cmd_wait_mem:   if (mem_cmd_yumi_i) state_n = e_cmd_header;
      default:          state_n = e_cmd_header;
    endcase
  end

  // Ready is registered so it stays low through reset and drops
  // right after the last payload flit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= e_cmd_header;
      ready_r <= 1'b0;
    end else begin
      state_r <= state_n;
      ready_r <= (state_n != e_cmd_wait_mem);
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_fire) begin
      case (state_r)
        e_cmd_header: begin
          src_route_r.cord <= hdr_in.src_cord;
          src_route_r.cid  <= hdr_in.src_cid;
          src_route_r.did  <= hdr_in.src_did;
        end
        e_cmd_payload_hi: payload_hi_r <= cmd_link_data_i;
        e_cmd_payload_lo: payload_lo_r <= cmd_link_data_i;
        default: ;
      endcase
    end
  end

  assign cmd_link_ready_o = ready_r;
  assign mem_cmd_o        = mem_msg_s'({payload_hi_r, payload_lo_r});

  // A command is only offered when its route has somewhere to go
  assign mem_cmd_v_o = (state_r == e_cmd_wait_mem) & route.push_ready;

  assign route.push_v     = mem_cmd_v_o & mem_cmd_yumi_i;
  assign route.push_route = src_route_r;

endmodule

// File: return_route_fifo.sv
module return_route_fifo (
  input  logic        clk_i,
  input  logic        rst_n_i,
  return_route_if.fifo route
);
  import noc_link_pkg::*;

  return_route_s                 mem_r [route_fifo_depth_lp];
  logic [route_ptr_width_lp-1:0] wr_ptr_r;
  logic [route_ptr_width_lp-1:0] rd_ptr_r;
  logic [route_ptr_width_lp:0]   count_r;
  logic                          push;
  logic                          pop;

  // Depth is a power of two, so the top count bit alone means full
  assign route.push_ready = ~count_r[route_ptr_width_lp];
  assign route.pop_v      = |count_r;
  assign route.pop_route  = mem_r[rd_ptr_r];

  assign push = route.push_v & route.push_ready;
  assign pop  = route.pop_yumi & route.pop_v;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= route.push_route;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_r <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// File: wh_resp_link_adapter.sv
module wh_resp_link_adapter (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  mem_msg_pkg::mem_msg_s                  mem_resp_i,
  input  logic                                   mem_resp_v_i,
  output logic                                   mem_resp_ready_o,
  return_route_if.reader                         route,
  output logic                                   resp_link_v_o,
  output logic [noc_link_pkg::flit_width_lp-1:0] resp_link_data_o,
  input  logic                                   resp_link_ready_i
);
  import noc_link_pkg::*;
  import mem_msg_pkg::*;

  typedef enum logic [1:0] {
    e_resp_idle,
    e_resp_header,
    e_resp_payload_hi,
    e_resp_payload_lo
  } resp_state_e;

  resp_state_e state_r;
  logic        accept;
  logic        flit_fire;
  logic        local_dst;
  wh_header_s  hdr_n;
  wh_header_s  hdr_r;
  mem_msg_s    resp_r;

  assign mem_resp_ready_o = (state_r == e_resp_idle) & route.pop_v;
  assign accept           = mem_resp_v_i & mem_resp_ready_o;
  assign route.pop_yumi   = accept;

  // Domain zero answers the sender directly, other domains leave through I/O
  assign local_dst = (route.pop_route.did == '0);

  always_comb begin
    hdr_n          = '0;
    hdr_n.dst_cord = local_dst ? route.pop_route.cord : io_cord_lp;
    hdr_n.len      = pkt_len_lp;
    hdr_n.src_cord = route.pop_route.cord;
    hdr_n.src_cid  = route.pop_route.cid;
    hdr_n.src_did  = route.pop_route.did;
    hdr_n.dst_cid  = local_dst ? route.pop_route.cid : '0;
    hdr_n.dst_did  = route.pop_route.did;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      hdr_r  <= hdr_n;
      resp_r <= mem_resp_i;
    end
  end

  assign flit_fire = resp_link_v_o & resp_link_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= e_resp_idle;
    end else begin
      case (state_r)
        e_resp_idle:       if (accept)    state_r <= e_resp_header;
        e_resp_header:     if (flit_fire) state_r <= e_resp_payload_hi;
        e_resp_payload_hi: if (flit_fire) state_r <= e_resp_payload_lo;
        e_resp_payload_lo: if (flit_fire) state_r <= e_resp_idle;
        default:                          state_r <= e_resp_idle;
      endcase
    end
  end

  assign resp_link_v_o = (state_r != e_resp_idle);

  always_comb begin
    case (state_r)
      e_resp_header:     resp_link_data_o = hdr_r;
      e_resp_payload_hi: resp_link_data_o = resp_r[mem_msg_width_lp-1 -: flit_width_lp];
      e_resp_payload_lo: resp_link_data_o = resp_r[flit_width_lp-1:0];
      default:           resp_link_data_o = '0;
    endcase
  end

endmodule

// File: mem_wormhole_link_client.sv
module mem_wormhole_link_client (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  input  logic                                   cmd_link_v_i,
  input  logic [noc_link_pkg::flit_width_lp-1:0] cmd_link_data_i,
  output logic                                   cmd_link_ready_o,

  output mem_msg_pkg::mem_msg_s                  mem_cmd_o,
  output logic                                   mem_cmd_v_o,
  input  logic                                   mem_cmd_yumi_i,

  input  mem_msg_pkg::mem_msg_s                  mem_resp_i,
  input  logic                                   mem_resp_v_i,
  output logic                                   mem_resp_ready_o,

  output logic                                   resp_link_v_o,
  output logic [noc_link_pkg::flit_width_lp-1:0] resp_link_data_o,
  input  logic                                   resp_link_ready_i
);

  // Return routes of commands that memory has taken but not yet answered
  return_route_if route_if ();

  wh_cmd_link_adapter u_cmd_adapter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd_link_v_i     (cmd_link_v_i),
    .cmd_link_data_i  (cmd_link_data_i),
    .cmd_link_ready_o (cmd_link_ready_o),
    .mem_cmd_o        (mem_cmd_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_yumi_i   (mem_cmd_yumi_i),
    .route            (route_if.writer)
  );

  return_route_fifo u_route_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .route   (route_if.fifo)
  );

  wh_resp_link_adapter u_resp_adapter (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .mem_resp_i        (mem_resp_i),
    .mem_resp_v_i      (mem_resp_v_i),
    .mem_resp_ready_o  (mem_resp_ready_o),
    .route             (route_if.reader),
    .resp_link_v_o     (resp_link_v_o),
    .resp_link_data_o  (resp_link_data_o),
    .resp_link_ready_i (resp_link_ready_i)
  );

endmodule

// File: tb_mem_wormhole_link_client.sv
module tb_mem_wormhole_link_client;
  import noc_link_pkg::*;
  import mem_msg_pkg::*;

  typedef struct {
    int                             test_id;
    logic [cord_width_lp-1:0]       cord;
    logic [cid_width_lp-1:0]        cid;
    logic [did_width_lp-1:0]        did;
    logic [mem_opcode_width_lp-1:0] opcode;
    logic [mem_addr_width_lp-1:0]   addr;
    logic [mem_data_width_lp-1:0]   data;
    logic [cord_width_lp-1:0]       exp_cord;
    logic [cid_width_lp-1:0]        exp_cid;
    logic [mem_data_width_lp-1:0]   exp_data;
  } vec_s;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     cmd_link_v_i;
  logic [flit_width_lp-1:0] cmd_link_data_i;
  logic                     cmd_link_ready_o;
  mem_msg_s                 mem_cmd_o;
  logic                     mem_cmd_v_o;
  logic                     mem_cmd_yumi_i;
  mem_msg_s                 mem_resp_i;
  logic                     mem_resp_v_i;
  logic                     mem_resp_ready_o;
  logic                     resp_link_v_o;
  logic [flit_width_lp-1:0] resp_link_data_o;
  logic                     resp_link_ready_i;

  vec_s     vecs[$];
  vec_s     cmd_exp_q[$];
  vec_s     pkt_exp_q[$];
  mem_msg_s resp_q[$];
  logic [mem_data_width_lp-1:0] mem_model [logic [mem_addr_width_lp-1:0]];

  int   seed = 16144;
  int   errors = 0;
  int   pass_count = 0;
  int   fail_count = 0;
  int   cmd_count = 0;
  int   packets_sent = 0;
  int   packets_done = 0;
  logic hold_resp = 1'b0;
  logic loaded = 1'b0;

  mem_wormhole_link_client DUT (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .cmd_link_v_i      (cmd_link_v_i),
    .cmd_link_data_i   (cmd_link_data_i),
    .cmd_link_ready_o  (cmd_link_ready_o),
    .mem_cmd_o         (mem_cmd_o),
    .mem_cmd_v_o       (mem_cmd_v_o),
    .mem_cmd_yumi_i    (mem_cmd_yumi_i),
    .mem_resp_i        (mem_resp_i),
    .mem_resp_v_i      (mem_resp_v_i),
    .mem_resp_ready_o  (mem_resp_ready_o),
    .resp_link_v_o     (resp_link_v_o),
    .resp_link_data_o  (resp_link_data_o),
    .resp_link_ready_i (resp_link_ready_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic load_golden();
    int    fd;
    int    got;
    string line;
    vec_s  v;
    fd = $fopen("golden_link_client.txt", "r");
    if (fd == 0) begin
      $display("could not open golden_link_client.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Comment and blank lines match no field and are skipped
        got = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", v.test_id, v.cord, v.cid,
                      v.did, v.opcode, v.addr, v.data, v.exp_cord, v.exp_cid, v.exp_data);
        if (got == 10) vecs.push_back(v);
      end
      $fclose(fd);
    end
  endtask

  // Called on a falling edge; returns on the falling edge after the transfer
  task automatic send_flit(input logic [flit_width_lp-1:0] flit);
    int waited;
    waited          = 0;
    cmd_link_v_i    = 1'b1;
    cmd_link_data_i = flit;
    while (!cmd_link_ready_o && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (!cmd_link_ready_o) begin
      $display("command link ready stayed low for %0d cycles at time %0t", waited, $time);
      errors++;
    end
    @(negedge clk_i);
    cmd_link_v_i = 1'b0;
  endtask

  task automatic issue(input vec_s v);
    wh_header_s hdr;
    hdr          = '0;
    hdr.dst_cord = 4'h8;
    hdr.len      = 2'd2;
    hdr.src_cord = v.cord;
    hdr.src_cid  = v.cid;
    hdr.src_did  = v.did;
    cmd_exp_q.push_back(v);
    pkt_exp_q.push_back(v);
    packets_sent++;
    send_flit(hdr);
    send_flit({v.opcode, v.addr});
    send_flit(v.data);
  endtask

  task automatic wait_packets(input int target, input int limit, input string what);
    int waited;
    waited = 0;
    while (packets_done < target && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (packets_done < target) begin
      $display("%s: %0d response packets missing after %0d cycles", what,
               target - packets_done, limit);
      errors++;
    end
  endtask

  task automatic wait_accepts(input int target, input int limit, input string what);
    int waited;
    waited = 0;
    while (cmd_count < target && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (cmd_count < target) begin
      $display("%s: memory saw %0d commands, %0d were due", what, cmd_count, target);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_count++;
      $display("%s passed", name);
    end else begin
      fail_count++;
      $display("%s failed with %0d errors", name, errors - err_before);
    end
  endtask

  // Memory controller model, answering in command order
  initial begin : memory_model
    mem_msg_s resp;
    vec_s     want;
    int       delay;
    logic     ready_seen;
    mem_cmd_yumi_i = 1'b0;
    mem_resp_v_i   = 1'b0;
    mem_resp_i     = '0;
    delay          = 0;
    ready_seen     = 1'b0;
    forever begin
      @(negedge clk_i);
      if (mem_resp_v_i && ready_seen) begin
        void'(resp_q.pop_front());
        mem_resp_v_i = 1'b0;
        delay        = $unsigned($random(seed)) % 6;
      end
      if (!mem_resp_v_i && resp_q.size() != 0 && !hold_resp) begin
        if (delay > 0) begin
          delay--;
        end else begin
          mem_resp_i   = resp_q[0];
          mem_resp_v_i = 1'b1;
        end
      end
      mem_cmd_yumi_i = 1'b0;
      if (mem_cmd_v_o) begin
        if (cmd_exp_q.size() == 0) begin
          $display("memory command offered at time %0t with no command sent", $time);
          errors++;
        end else begin
          want = cmd_exp_q.pop_front();
          if (mem_cmd_o.opcode != want.opcode || mem_cmd_o.addr != want.addr ||
              mem_cmd_o.data != want.data) begin
            $display("error %0t: test %0d memory command %h, expected %h", $time,
                     want.test_id, mem_cmd_o, {want.opcode, want.addr, want.data});
            errors++;
          end
        end
        resp.opcode = mem_cmd_o.opcode;
        resp.addr   = mem_cmd_o.addr;
        if (mem_cmd_o.opcode == e_mem_wr) begin
          mem_model[mem_cmd_o.addr] = mem_cmd_o.data;
          resp.data = mem_cmd_o.data;
        end else begin
          resp.data = mem_model.exists(mem_cmd_o.addr) ? mem_model[mem_cmd_o.addr] : '0;
        end
        resp_q.push_back(resp);
        mem_cmd_yumi_i = 1'b1;
        cmd_count++;
      end
      ready_seen = mem_resp_ready_o;
    end
  end

  initial begin : resp_link_monitor
    vec_s       cur;
    wh_header_s hdr;
    int         flit_idx;
    flit_idx          = 0;
    resp_link_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      resp_link_ready_i = ($unsigned($random(seed)) % 4) != 0;
      if (resp_link_v_o && resp_link_ready_i) begin
        if (flit_idx == 0) begin
          if (pkt_exp_q.size() == 0) begin
            $display("response flit at time %0t with no response outstanding", $time);
            errors++;
          end else begin
            cur      = pkt_exp_q.pop_front();
            hdr      = wh_header_s'(resp_link_data_o);
            flit_idx = 1;
            if (hdr.dst_cord != cur.exp_cord || hdr.dst_cid != cur.exp_cid) begin
              $display("error %0t: test %0d destination %h.%h, expected %h.%h", $time,
                       cur.test_id, hdr.dst_cord, hdr.dst_cid, cur.exp_cord, cur.exp_cid);
              errors++;
            end
            if (hdr.len != 2'd2 || hdr.dst_did != cur.did) begin
              $display("error %0t: test %0d length %0d domain %0d, expected 2 and %0d",
                       $time, cur.test_id, hdr.len, hdr.dst_did, cur.did);
              errors++;
            end
          end
        end else if (flit_idx == 1) begin
          flit_idx = 2;
          if (resp_link_data_o != {cur.opcode, cur.addr}) begin
            $display("error %0t: test %0d upper payload %h, expected %h", $time,
                     cur.test_id, resp_link_data_o, {cur.opcode, cur.addr});
            errors++;
          end
        end else begin
          flit_idx = 0;
          packets_done++;
          if (resp_link_data_o != cur.exp_data) begin
            $display("error %0t: test %0d response data %h, expected %h", $time,
                     cur.test_id, resp_link_data_o, cur.exp_data);
            errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (vecs.size() * 200 + 2000) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d clock cycles",
             vecs.size() * 200 + 2000);
    $display("tests failed");
    $finish;
  end

  initial begin : sequencer
    int   err_before;
    int   base;
    int   k;
    logic offered;
    rst_n_i         = 1'b0;
    cmd_link_v_i    = 1'b0;
    cmd_link_data_i = '0;
    load_golden();
    loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (vecs.size() == 0) begin
      $display("golden file holds no test vectors");
      errors++;
    end else begin
      foreach (vecs[i]) begin
        err_before = errors;
        issue(vecs[i]);
        wait_packets(packets_sent, 200, $sformatf("test %0d", vecs[i].test_id));
        report_test($sformatf("test %0d", vecs[i].test_id), err_before);
      end
      // Memory sits on its answers until the route FIFO is full
      err_before = errors;
      base       = cmd_count;
      hold_resp  = 1'b1;
      for (k = 0; k < route_fifo_depth_lp; k++) begin
        issue(vecs[k % vecs.size()]);
      end
      wait_accepts(base + route_fifo_depth_lp, 200, "route FIFO fill");
      issue(vecs[route_fifo_depth_lp % vecs.size()]);
      offered = 1'b0;
      repeat (20) begin
        @(negedge clk_i);
        if (mem_cmd_v_o || cmd_count != base + route_fifo_depth_lp) offered = 1'b1;
      end
      if (offered) begin
        $display("error %0t: command offered to memory while the route FIFO was full", $time);
        errors++;
      end
      hold_resp = 1'b0;
      wait_accepts(base + route_fifo_depth_lp + 1, 200, "held command");
      wait_packets(packets_sent, 1000, "burst test");
      report_test("burst test", err_before);
    end
    repeat (2) @(negedge clk_i);
    if (resp_link_v_o || mem_cmd_v_o) begin
      $display("a valid output stayed high after the last response");
      errors++;
    end
    $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count,
             pass_count, fail_count);
    if (errors == 0 && fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: golden_link_client.txt
# test src_cord src_cid src_did opcode addr data exp_dst_cord exp_dst_cid exp_resp_data
# All fields but the test number are hex; opcode 0 read, 1 write, 2 uncached read
1 3 1 0 1 0000100 deadbeef 3 1 deadbeef
2 3 1 0 0 0000100 00000000 3 1 deadbeef
3 5 2 1 1 0000200 12345678 0 0 12345678
4 7 0 2 0 0000200 00000000 0 0 12345678
5 a 3 0 2 0000100 00000000 a 3 deadbeef
6 f 3 3 0 0abcdef 00000000 0 0 00000000
7 1 0 0 1 0000300 cafef00d 1 0 cafef00d
8 2 1 0 0 0000300 00000000 2 1 cafef00d
9 c 2 1 1 fffffff 0badc0de 0 0 0badc0de
10 e 1 0 0 fffffff 00000000 e 1 0badc0de
11 4 2 0 2 0000400 00000000 4 2 00000000
12 9 1 2 1 0000500 a5a5a5a5 0 0 a5a5a5a5
13 b 0 0 0 0000500 00000000 b 0 a5a5a5a5
14 6 3 1 0 0000300 00000000 0 0 cafef00d

// File: mem_wormhole_link_client.f
noc_link_pkg.sv
mem_msg_pkg.sv
return_route_if.sv
wh_cmd_link_adapter.sv
return_route_fifo.sv
wh_resp_link_adapter.sv
mem_wormhole_link_client.sv
tb_mem_wormhole_link_client.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

top=tb_mem_wormhole_link_client
log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module "$top" -f mem_wormhole_link_client.f
./obj_dir/V"$top" | tee "$log"

if grep -qx "all tests passed" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
